//--- rtl/aesTypesPkg.sv
// ======================================
// vector types and round counts shared by
// the AES-128 datapath
// ======================================
`default_nettype none

package aesTypesPkg;

  // one cipher state or data block
  typedef logic [127:0] blockT;

  // cipher key or one expanded round key
  typedef logic [127:0] keyT;

  // key-schedule word or state column
  typedef logic [31:0] wordT;

  // one element of GF(2^8)
  typedef logic [7:0] byteT;

  // round number, 0 to 10
  typedef logic [3:0] roundIdxT;

  localparam int NumRounds = 10;

  // key 0 is the raw key, so the final key sits at the round count
  localparam roundIdxT LastKeyIdx = roundIdxT'(NumRounds);

endpackage

`default_nettype wire

//--- rtl/aesGfPkg.sv
// ======================================
// GF(2^8) arithmetic, S-box and the AES
// byte, row and column transforms
// ======================================
`default_nettype none

package aesGfPkg;
  import aesTypesPkg::*;

  // multiply by x, reduced by the AES polynomial
  function automatic byteT gfDouble(input byteT b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic byteT gfMul(input byteT a, input byteT b);
    byteT acc;
    byteT p;
    acc = '0;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ p;
      end
      p = gfDouble(p);
    end
    return acc;
  endfunction

  // inverse as a^254, which also maps zero to zero
  function automatic byteT gfInv(input byteT a);
    byteT r;
    byteT sq;
    r = 8'h01;
    sq = a;
    for (int i = 1; i < 8; i++) begin
      sq = gfMul(sq, sq);
      r = gfMul(r, sq);
    end
    return r;
  endfunction

  function automatic byteT rotl8(input byteT b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  function automatic byteT sboxByte(input byteT b);
    byteT x;
    x = gfInv(b);
    return x ^ rotl8(x, 1) ^ rotl8(x, 2) ^ rotl8(x, 3) ^ rotl8(x, 4) ^ 8'h63;
  endfunction

  // undo the affine map first, then invert
  function automatic byteT invSboxByte(input byteT b);
    return gfInv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
  endfunction

  function automatic wordT subWord(input wordT w);
    wordT r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = sboxByte(w[8*i +: 8]);
    end
    return r;
  endfunction

  function automatic wordT rotWord(input wordT w);
    return {w[23:0], w[31:24]};
  endfunction

  function automatic blockT subBytes(input blockT s);
    blockT r;
    for (int i = 0; i < 16; i++) begin
      r[8*i +: 8] = sboxByte(s[8*i +: 8]);
    end
    return r;
  endfunction

  function automatic blockT invSubBytes(input blockT s);
    blockT r;
    for (int i = 0; i < 16; i++) begin
      r[8*i +: 8] = invSboxByte(s[8*i +: 8]);
    end
    return r;
  endfunction

  // byte r + 4c sits at bits 127 - 8(r + 4c), columns are 32-bit words
  function automatic blockT shiftRows(input blockT s);
    blockT r;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
      end
    end
    return r;
  endfunction

  function automatic blockT invShiftRows(input blockT s);
    blockT r;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + 4 - row) % 4) + row) -: 8];
      end
    end
    return r;
  endfunction

  // one column times a circulant matrix with first row k0..k3
  function automatic wordT mixWord(input wordT w, input byteT k0, input byteT k1,
                                   input byteT k2, input byteT k3);
    byteT a [4];
    wordT r;
    for (int i = 0; i < 4; i++) begin
      a[i] = w[31 - 8*i -: 8];
    end
    for (int i = 0; i < 4; i++) begin
      r[31 - 8*i -: 8] = gfMul(k0, a[i]) ^ gfMul(k1, a[(i + 1) % 4])
                       ^ gfMul(k2, a[(i + 2) % 4]) ^ gfMul(k3, a[(i + 3) % 4]);
    end
    return r;
  endfunction

  function automatic blockT mixColumns(input blockT s);
    blockT r;
    for (int c = 0; c < 4; c++) begin
      r[127 - 32*c -: 32] = mixWord(s[127 - 32*c -: 32], 8'h02, 8'h03, 8'h01, 8'h01);
    end
    return r;
  endfunction

  function automatic blockT invMixColumns(input blockT s);
    blockT r;
    for (int c = 0; c < 4; c++) begin
      r[127 - 32*c -: 32] = mixWord(s[127 - 32*c -: 32], 8'h0e, 8'h0b, 8'h0d, 8'h09);
    end
    return r;
  endfunction

endpackage

`default_nettype wire

//--- rtl/keyExpander.sv
// ======================================
// AES-128 key schedule, one round key
// written to the store per cycle
// ======================================
`timescale 1ns/1ps
`default_nettype none

module keyExpander
  import aesTypesPkg::*, aesGfPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     keyLoad,
  input  keyT      key,
  output logic     wrEn,
  output roundIdxT wrIdx,
  output keyT      wrKey
);

  typedef enum logic {IDLE, EXPAND} expandStateT;

  expandStateT state;
  roundIdxT    roundIdx;
  byteT        rcon;
  wordT        w0, w1, w2, w3;
  wordT        t, n0, n1, n2, n3;

  // next round key from the four current words
  assign t  = subWord(rotWord(w3)) ^ {rcon, 24'h000000};
  assign n0 = w0 ^ t;
  assign n1 = n0 ^ w1;
  assign n2 = n1 ^ w2;
  assign n3 = n2 ^ w3;

  // key 0 goes straight through on the load cycle
  assign wrEn  = keyLoad || (state == EXPAND);
  assign wrIdx = keyLoad ? roundIdxT'(0) : roundIdx;
  assign wrKey = keyLoad ? key : {n0, n1, n2, n3};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      roundIdx <= '0;
    end else if (keyLoad) begin
      state    <= EXPAND;
      roundIdx <= roundIdxT'(1);
    end else if (state == EXPAND) begin
      roundIdx <= roundIdx + roundIdxT'(1);
      if (roundIdx == LastKeyIdx) begin
        state <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keyLoad) begin
      {w0, w1, w2, w3} <= key;
      rcon             <= 8'h01;
    end else if (state == EXPAND) begin
      {w0, w1, w2, w3} <= {n0, n1, n2, n3};
      rcon             <= gfDouble(rcon);
    end
  end

endmodule

`default_nettype wire

//--- rtl/roundKeyStore.sv
// ======================================
// eleven round keys with a ready flag
// ======================================
`timescale 1ns/1ps
`default_nettype none

module roundKeyStore
  import aesTypesPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wrEn,
  input  roundIdxT wrIdx,
  input  keyT      wrKey,
  input  roundIdxT rdIdx,
  output keyT      rdKey,
  output logic     keysReady
);

  keyT keys [0:NumRounds];

  always_ff @(posedge clk) begin
    if (wrEn) begin
      keys[wrIdx] <= wrKey;
    end
  end

  // key 0 starts a new schedule, the last key completes it
  always_ff @(posedge clk) begin
    if (rst) begin
      keysReady <= 1'b0;
    end else if (wrEn && wrIdx == roundIdxT'(0)) begin
      keysReady <= 1'b0;
    end else if (wrEn && wrIdx == LastKeyIdx) begin
      keysReady <= 1'b1;
    end
  end

  assign rdKey = keys[rdIdx];

endmodule

`default_nettype wire

//--- rtl/cipherRounds.sv
// ======================================
// round engine: control FSM and the
// encrypt and decrypt round datapath
// ======================================
`timescale 1ns/1ps
`default_nettype none

module cipherRounds
  import aesTypesPkg::*, aesGfPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  logic     decrypt,
  input  blockT    dataIn,
  input  logic     keysReady,
  input  keyT      rdKey,
  output logic     keyLoad,
  output roundIdxT rdIdx,
  output logic     busy,
  output logic     done,
  output blockT    dataOut
);

  typedef enum logic [1:0] {IDLE, WAIT_KEYS, ROUNDS, DONE} engineStateT;

  engineStateT state;
  roundIdxT    round;
  logic        decMode;
  blockT       cipherState;
  blockT       encShift, encOut;
  blockT       decAdd, decOut;
  blockT       nextState;

  assign keyLoad = start && (state == IDLE);
  assign busy    = (state != IDLE);
  assign done    = (state == DONE);

  // decryption walks the schedule backwards
  assign rdIdx = decMode ? roundIdxT'(LastKeyIdx - round) : round;

  // forward round, no column mixing in the last one
  assign encShift = shiftRows(subBytes(cipherState));
  assign encOut   = ((round == LastKeyIdx) ? encShift : mixColumns(encShift)) ^ rdKey;

  // inverse round
  assign decAdd = invSubBytes(invShiftRows(cipherState)) ^ rdKey;
  assign decOut = (round == LastKeyIdx) ? decAdd : invMixColumns(decAdd);

  assign nextState = decMode ? decOut : encOut;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      round   <= '0;
      decMode <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= WAIT_KEYS;
            round   <= '0;
            decMode <= decrypt;
          end
        end
        WAIT_KEYS: begin
          if (keysReady) begin
            state <= ROUNDS;
            round <= roundIdxT'(1);
          end
        end
        ROUNDS: begin
          if (round == LastKeyIdx) begin
            state <= DONE;
          end else begin
            round <= round + roundIdxT'(1);
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (start) begin
          cipherState <= dataIn;
        end
      end
      WAIT_KEYS: begin
        // initial key addition
        if (keysReady) begin
          cipherState <= cipherState ^ rdKey;
        end
      end
      ROUNDS: begin
        cipherState <= nextState;
        if (round == LastKeyIdx) begin
          dataOut <= nextState;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/aesCore.sv
// ======================================
// AES-128 core: key expander, round-key
// store and round engine
// ======================================
`timescale 1ns/1ps
`default_nettype none

module aesCore
  import aesTypesPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  decrypt,
  input  keyT   key,
  input  blockT dataIn,
  output logic  busy,
  output logic  done,
  output blockT dataOut
);

  logic     keyLoad;
  logic     wrEn;
  roundIdxT wrIdx;
  keyT      wrKey;
  roundIdxT rdIdx;
  keyT      rdKey;
  logic     keysReady;

  keyExpander keyExpander_i (
    .clk     (clk),
    .rst     (rst),
    .keyLoad (keyLoad),
    .key     (key),
    .wrEn    (wrEn),
    .wrIdx   (wrIdx),
    .wrKey   (wrKey)
  );

  roundKeyStore roundKeyStore_i (
    .clk       (clk),
    .rst       (rst),
    .wrEn      (wrEn),
    .wrIdx     (wrIdx),
    .wrKey     (wrKey),
    .rdIdx     (rdIdx),
    .rdKey     (rdKey),
    .keysReady (keysReady)
  );

  cipherRounds cipherRounds_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .decrypt   (decrypt),
    .dataIn    (dataIn),
    .keysReady (keysReady),
    .rdKey     (rdKey),
    .keyLoad   (keyLoad),
    .rdIdx     (rdIdx),
    .busy      (busy),
    .done      (done),
    .dataOut   (dataOut)
  );

endmodule

`default_nettype wire

//--- tests/aesCoreTb.sv
// ======================================
// testbench for the AES-128 core: known
// answers, latency, round trips, busy
// ======================================
`timescale 1ns/1ps
`default_nettype none

module aesCoreTb
  import aesTypesPkg::*;
();

  localparam int VecCount      = 10;
  localparam int DoneLatency   = 21;
  localparam int TimeoutCycles = 100;
  localparam int RandomOps     = 20;

  logic  clk;
  logic  rst;
  logic  start;
  logic  decrypt;
  keyT   key;
  blockT dataIn;
  logic  busy;
  logic  done;
  blockT dataOut;

  // four words per vector: mode, key, input block, expected block
  logic [127:0] vecMem [0:4*VecCount-1];
  integer       seed;

  aesCore aesCore_i (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .decrypt (decrypt),
    .key     (key),
    .dataIn  (dataIn),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut)
  );

  always #4 clk = ~clk;

  task automatic checkEq(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic failNow(input string what);
    $display("ERROR: %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  // called 1 ns after an edge with the core idle, returns 1 ns after the edge ending done
  task automatic runOp(input string name, input logic mode, input keyT k, input blockT din,
                       output blockT result);
    int edges;
    decrypt = mode;
    key     = k;
    dataIn  = din;
    start   = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    checkEq($sformatf("%s busy after start", name), 128'(1'b1), 128'(busy));
    edges = 0;
    while (done !== 1'b1) begin
      if (edges >= TimeoutCycles) begin
        failNow($sformatf("timeout while waiting for done in %s", name));
      end
      @(posedge clk);
      #1;
      edges++;
    end
    checkEq($sformatf("%s latency", name), 128'(DoneLatency), 128'(edges));
    result = dataOut;
    @(posedge clk);
    #1;
    checkEq($sformatf("%s done width", name), 128'(1'b0), 128'(done));
    checkEq($sformatf("%s busy after done", name), 128'(1'b0), 128'(busy));
  endtask

  // a second start five cycles in must leave the first operation untouched
  task automatic startWhileBusy(input keyT k, input blockT din, input blockT expected);
    int    doneCount;
    int    doneEdge;
    blockT firstOut;
    decrypt = 1'b0;
    key     = k;
    dataIn  = din;
    start   = 1'b1;
    @(posedge clk);
    #1;
    start     = 1'b0;
    doneCount = 0;
    doneEdge  = 0;
    firstOut  = '0;
    for (int edges = 1; edges <= 2 * DoneLatency; edges++) begin
      if (edges == 5) begin
        start   = 1'b1;
        decrypt = 1'b1;
        key     = ~k;
        dataIn  = ~din;
      end
      @(posedge clk);
      #1;
      start = 1'b0;
      if (done === 1'b1) begin
        doneCount++;
        if (doneCount == 1) begin
          doneEdge = edges;
          firstOut = dataOut;
        end
      end
    end
    checkEq("busy start done count", 128'(1), 128'(doneCount));
    checkEq("busy start latency", 128'(DoneLatency), 128'(doneEdge));
    checkEq("busy start result", expected, firstOut);
  endtask

  initial begin
    blockT result;
    blockT plain;
    blockT cipher;
    keyT   randKey;
    string vecName;
    clk     = 1'b0;
    rst     = 1'b1;
    start   = 1'b0;
    decrypt = 1'b0;
    key     = '0;
    dataIn  = '0;
    seed    = 70;

    // a fill that no valid mode word can hold
    for (int i = 0; i < 4 * VecCount; i++) begin
      vecMem[i] = {4{~32'(i)}};
    end
    $readmemh("tests/aesCorePatterns.hex", vecMem);
    for (int i = 0; i < VecCount; i++) begin
      if (vecMem[4*i] > 128'd1) begin
        failNow("pattern file is missing or holds too few vectors");
      end
    end

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    checkEq("reset busy", 128'(1'b0), 128'(busy));
    checkEq("reset done", 128'(1'b0), 128'(done));

    for (int i = 0; i < VecCount; i++) begin
      vecName = $sformatf("vector %0d", i);
      runOp(vecName, vecMem[4*i][0], vecMem[4*i+1], vecMem[4*i+2], result);
      checkEq(vecName, vecMem[4*i+3], result);
    end

    for (int i = 0; i < RandomOps; i++) begin
      randKey = {$random(seed), $random(seed), $random(seed), $random(seed)};
      plain   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      runOp($sformatf("random encrypt %0d", i), 1'b0, randKey, plain, cipher);
      runOp($sformatf("random decrypt %0d", i), 1'b1, randKey, cipher, result);
      checkEq($sformatf("round trip %0d", i), plain, result);
    end

    // first vector is the FIPS-197 encryption
    startWhileBusy(vecMem[1], vecMem[2], vecMem[3]);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- aesCore.f
rtl/aesTypesPkg.sv
rtl/aesGfPkg.sv
rtl/keyExpander.sv
rtl/roundKeyStore.sv
rtl/cipherRounds.sv
rtl/aesCore.sv
tests/aesCoreTb.sv

//--- Makefile
TOP = aesCoreTb
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f aesCore.f --top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f aesCore.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

//--- tests/aesCorePatterns.hex
// columns: mode (0 encrypt, 1 decrypt), key, dataIn, expected dataOut
// FIPS-197 appendix C.1, then SP 800-38A F.1.1 and F.1.2 (ECB-AES128)
0 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
1 000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
0 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
0 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
0 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
0 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
1 2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
1 2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
1 2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
1 2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710
